/* hdl/jpeg_capture_pkg.sv */
// jpeg capture shared types
package jpeg_capture_pkg;

    // one luma sample
    typedef logic [7:0] pixel_t;

    // one image buffer word
    typedef logic [31:0] word_t;     // pixel 0 sits in bits 7:0

    // capture controller states
    typedef enum logic [2:0] {
        cap_idle,                    // idle or holding a finished image
        cap_arm,                     // armed and waiting for a running frame to end
        cap_wait_frame,              // waiting for the next frame start
        cap_capture,                 // pixels flow into the buffer
        cap_done                     // image valid
    } capture_state_t;

    // luma weights on the upper 8 bits of each colour
    // weights add up to 256 so the sum is shifted right by 8
    localparam int LUMA_R = 77;
    localparam int LUMA_G = 150;
    localparam int LUMA_B = 29;

endpackage

/* hdl/buf_req_if.sv */
// image buffer request bus
`timescale 1ns/10ps

interface buf_req_if #(
    parameter int ADDR_W = 12        // word address width
);

    logic                    req;    // held with its fields until gnt
    logic                    we;     // 1 for write, 0 for read
    logic [ADDR_W-1:0]       addr;   // word address
    jpeg_capture_pkg::word_t wdata;  // write data
    logic                    gnt;    // transfer takes place in this cycle
    jpeg_capture_pkg::word_t rdata;  // valid the cycle after gnt

    // side that asks for buffer access
    modport master (
        output req, we, addr, wdata,
        input  gnt, rdata
    );

    // side that owns the RAM
    modport buffer (
        input  req, we, addr, wdata,
        output gnt, rdata
    );

endinterface

/* hdl/luma_convert.sv */
// rgb to luma stage
`timescale 1ns/10ps

module luma_convert (
    input  logic                     jpeg_fast_clock_in,
    input  logic                     jpeg_fast_reset_n_in,
    input  logic [9:0]               red,
    input  logic [9:0]               green,
    input  logic [9:0]               blue,
    input  logic                     frame_valid_in,
    input  logic                     line_valid_in,
    input  logic                     enable,            // high only inside the capture window
    output jpeg_capture_pkg::pixel_t luma,
    output logic                     luma_frame_valid,
    output logic                     luma_line_valid
);

    logic [15:0] weighted;                              // at most 256*255

    // weighted sum over the upper 8 bits
    always_comb begin
        weighted = 16'(jpeg_capture_pkg::LUMA_R) * 16'(red[9:2])
                 + 16'(jpeg_capture_pkg::LUMA_G) * 16'(green[9:2])
                 + 16'(jpeg_capture_pkg::LUMA_B) * 16'(blue[9:2]);
    end

    always_ff @(posedge jpeg_fast_clock_in) begin
        luma <= weighted[15:8];                         // divide by 256
    end

    // valids line up with luma one cycle later
    always_ff @(posedge jpeg_fast_clock_in) begin
        if (!jpeg_fast_reset_n_in) begin
            luma_frame_valid <= 1'b0;
            luma_line_valid  <= 1'b0;
        end else begin
            luma_frame_valid <= enable & frame_valid_in;
            luma_line_valid  <= enable & frame_valid_in & line_valid_in;
        end
    end

endmodule

/* hdl/frame_packer.sv */
// luma crop and word packer
`timescale 1ns/10ps

module frame_packer #(
    parameter int SENSOR_X_SIZE = 720,
    parameter int SENSOR_Y_SIZE = 720,
    parameter int BUF_WORDS     = 4096
)(
    input  logic                                            jpeg_fast_clock_in,
    input  logic                                            jpeg_fast_reset_n_in,
    input  logic                                            clear,  // restart address and count
    input  jpeg_capture_pkg::pixel_t                        luma,
    input  logic                                            luma_frame_valid,
    input  logic                                            luma_line_valid,
    input  logic [$clog2(SENSOR_X_SIZE+1)-1:0]              x_size_in,
    input  logic [$clog2(SENSOR_Y_SIZE+1)-1:0]              y_size_in,
    buf_req_if.master                                       wr_bus,
    output logic                                            done,
    output logic [$clog2(SENSOR_X_SIZE*SENSOR_Y_SIZE+1)-1:0] byte_count
);

    localparam int XW = $clog2(SENSOR_X_SIZE + 1);
    localparam int YW = $clog2(SENSOR_Y_SIZE + 1);
    localparam int AW = $clog2(BUF_WORDS);

    logic [XW-1:0]           col;         // pixel position in the line
    logic [YW-1:0]           row;         // line position in the frame
    logic                    lv_q;
    logic                    fv_q;
    logic                    accept;      // pixel inside the crop
    logic                    line_fall;
    logic                    frame_fall;
    logic                    slot_free;   // pending slot empty or leaving now
    logic [1:0]              lane;        // pixels already in shift_word
    logic                    flush_due;   // frame ended, tail not handled yet
    jpeg_capture_pkg::word_t shift_word;  // new pixels enter at the top byte
    jpeg_capture_pkg::word_t pend_word;
    logic                    pend_valid;
    logic                    pend_last;   // pending word is the zero padded tail
    logic [AW-1:0]           wr_addr;

    always_comb begin
        accept     = luma_frame_valid & luma_line_valid & (col < x_size_in) & (row < y_size_in);
        line_fall  = lv_q & ~luma_line_valid;
        frame_fall = fv_q & ~luma_frame_valid;
        slot_free  = ~pend_valid | wr_bus.gnt;
        // last write granted, or nothing left to write at frame end
        done       = (wr_bus.gnt & pend_last) | (flush_due & (lane == 2'd0) & slot_free);
    end

    // crop counters, both saturate so long lines never wrap back into the crop
    always_ff @(posedge jpeg_fast_clock_in) begin
        if (!jpeg_fast_reset_n_in || clear) begin
            col  <= '0;
            row  <= '0;
            lv_q <= 1'b0;
            fv_q <= 1'b0;
        end else begin
            lv_q <= luma_line_valid;
            fv_q <= luma_frame_valid;
            if (!luma_line_valid)
                col <= '0;
            else if (col != '1)
                col <= col + 1'b1;
            if (!luma_frame_valid)
                row <= '0;
            else if (line_fall && row != '1)
                row <= row + 1'b1;                      // next line
        end
    end

    // word assembly control
    always_ff @(posedge jpeg_fast_clock_in) begin
        if (!jpeg_fast_reset_n_in || clear) begin
            lane       <= 2'd0;
            flush_due  <= 1'b0;
            pend_valid <= 1'b0;
            pend_last  <= 1'b0;
            wr_addr    <= '0;
            byte_count <= '0;
        end else begin
            if (accept) begin
                lane       <= lane + 1'b1;              // wraps after the fourth pixel
                byte_count <= byte_count + 1'b1;
            end
            if (frame_fall)
                flush_due <= 1'b1;
            if (accept && lane == 2'd3) begin
                pend_valid <= 1'b1;                     // full word
                pend_last  <= 1'b0;
            end else if (flush_due && slot_free) begin
                flush_due  <= 1'b0;
                lane       <= 2'd0;
                pend_valid <= (lane != 2'd0);           // partial tail only
                pend_last  <= (lane != 2'd0);
            end else if (wr_bus.gnt) begin
                pend_valid <= 1'b0;
                pend_last  <= 1'b0;
            end
            if (wr_bus.gnt)
                wr_addr <= wr_addr + 1'b1;
        end
    end

    // payload
    always_ff @(posedge jpeg_fast_clock_in) begin
        if (accept)
            shift_word <= {luma, shift_word[31:8]};
        if (accept && lane == 2'd3)
            pend_word <= {luma, shift_word[31:8]};
        else if (flush_due && slot_free)
            pend_word <= shift_word >> (6'd32 - {lane, 3'b000});  // move pixel 0 down, pad zeros
    end

    assign wr_bus.req   = pend_valid;
    assign wr_bus.we    = 1'b1;                         // write only
    assign wr_bus.addr  = wr_addr;
    assign wr_bus.wdata = pend_word;

endmodule

/* hdl/shared_image_buffer.sv */
// arbitrated image buffer
`timescale 1ns/10ps

module shared_image_buffer #(
    parameter int BUF_WORDS = 4096
)(
    input  logic      jpeg_fast_clock_in,
    input  logic      jpeg_fast_reset_n_in,
    buf_req_if.buffer wr_bus,                   // frame writer
    buf_req_if.buffer rd_bus                    // apb reader
);

    localparam int AW = $clog2(BUF_WORDS);

    jpeg_capture_pkg::word_t mem [BUF_WORDS];   // single port word RAM
    jpeg_capture_pkg::word_t rdata_q;
    logic                    last_wr;           // writer won the last grant
    logic                    gnt_wr;
    logic                    gnt_rd;
    logic                    acc_en;
    logic                    acc_we;
    logic [AW-1:0]           acc_addr;
    jpeg_capture_pkg::word_t acc_wdata;

    // round robin between two masters
    always_comb begin
        gnt_wr = wr_bus.req & (~rd_bus.req | ~last_wr);  // writer wins unless it won last time
        gnt_rd = rd_bus.req & ~gnt_wr;
        acc_en = gnt_wr | gnt_rd;
    end

    // winner's fields go to the RAM port
    always_comb begin
        if (gnt_wr) begin
            acc_we    = wr_bus.we;
            acc_addr  = wr_bus.addr;
            acc_wdata = wr_bus.wdata;
        end else begin
            acc_we    = rd_bus.we;
            acc_addr  = rd_bus.addr;
            acc_wdata = rd_bus.wdata;
        end
    end

    // priority flips after every grant
    always_ff @(posedge jpeg_fast_clock_in) begin
        if (!jpeg_fast_reset_n_in)
            last_wr <= 1'b0;
        else if (gnt_wr)
            last_wr <= 1'b1;
        else if (gnt_rd)
            last_wr <= 1'b0;
    end

    // RAM access, read data one cycle after gnt
    always_ff @(posedge jpeg_fast_clock_in) begin
        if (acc_en) begin
            if (acc_we)
                mem[acc_addr] <= acc_wdata;
            else
                rdata_q <= mem[acc_addr];
        end
    end

    assign wr_bus.gnt   = gnt_wr;
    assign rd_bus.gnt   = gnt_rd;
    assign wr_bus.rdata = rdata_q;              // shared read register
    assign rd_bus.rdata = rdata_q;

endmodule

/* hdl/apb_buffer_reader.sv */
// apb read port for the image buffer
`timescale 1ns/10ps

module apb_buffer_reader #(
    parameter int BUF_WORDS = 4096
)(
    input  logic                    jpeg_fast_clock_in,
    input  logic                    jpeg_fast_reset_n_in,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [15:0]             paddr,      // byte address
    output jpeg_capture_pkg::word_t prdata,
    output logic                    pready,
    output logic                    pslverr,
    buf_req_if.master               rd_bus
);

    localparam int AW = $clog2(BUF_WORDS);

    typedef enum logic {rd_request, rd_return} rd_state_t;

    rd_state_t state;
    logic      access;                          // apb access phase
    logic      bad;                             // write or out of range
    logic      req;

    always_comb begin
        access = psel & penable;
        bad    = pwrite | (32'(paddr) >= 32'(4 * BUF_WORDS));
        req    = access & ~bad & (state == rd_request);  // held until gnt
    end

    // apb response
    always_comb begin
        pready  = 1'b0;
        pslverr = 1'b0;
        prdata  = '0;
        if (state == rd_return) begin
            pready = 1'b1;
            prdata = rd_bus.rdata;              // valid the cycle after gnt
        end else if (access && bad) begin
            pready  = 1'b1;                     // error at once, no buffer access
            pslverr = 1'b1;
        end
    end

    always_ff @(posedge jpeg_fast_clock_in) begin
        if (!jpeg_fast_reset_n_in)
            state <= rd_request;
        else if (state == rd_request)
            state <= (req && rd_bus.gnt) ? rd_return : rd_request;
        else
            state <= rd_request;                // one data cycle
    end

    assign rd_bus.req   = req;
    assign rd_bus.we    = 1'b0;
    assign rd_bus.addr  = paddr[AW+1:2];        // word index
    assign rd_bus.wdata = '0;

endmodule

/* hdl/jpeg_encoder.sv */
// camera frame capture top level
`timescale 1ns/10ps

module jpeg_encoder #(
    parameter int SENSOR_X_SIZE = 720,
    parameter int SENSOR_Y_SIZE = 720,
    parameter int BUF_WORDS     = 4096
)(
    input  logic                                            jpeg_fast_clock_in,
    input  logic                                            jpeg_fast_reset_n_in,
    input  logic                                            start_capture_in,
    input  logic [9:0]                                      red_data_in,
    input  logic [9:0]                                      green_data_in,
    input  logic [9:0]                                      blue_data_in,
    input  logic                                            frame_valid_in,
    input  logic                                            line_valid_in,
    input  logic [$clog2(SENSOR_X_SIZE+1)-1:0]              x_size_in,
    input  logic [$clog2(SENSOR_Y_SIZE+1)-1:0]              y_size_in,
    input  logic                                            psel,
    input  logic                                            penable,
    input  logic                                            pwrite,
    input  logic [15:0]                                     paddr,
    output jpeg_capture_pkg::word_t                         prdata,
    output logic                                            pready,
    output logic                                            pslverr,
    output logic                                            image_valid_out,
    output logic [$clog2(SENSOR_X_SIZE*SENSOR_Y_SIZE+1)-1:0] image_bytes_out
);

    localparam int AW = $clog2(BUF_WORDS);

    jpeg_capture_pkg::capture_state_t state;
    logic                     luma_en;           // pixels pass only while capturing
    jpeg_capture_pkg::pixel_t luma;
    logic                     luma_frame_valid;
    logic                     luma_line_valid;
    logic                     packer_clear;
    logic                     packer_done;

    buf_req_if #(.ADDR_W(AW)) wr_bus ();
    buf_req_if #(.ADDR_W(AW)) rd_bus ();

    // capture controller
    always_ff @(posedge jpeg_fast_clock_in) begin
        if (!jpeg_fast_reset_n_in) begin
            state <= jpeg_capture_pkg::cap_idle;
        end else begin
            case (state)
                jpeg_capture_pkg::cap_arm:                  // let a running frame finish
                    if (!frame_valid_in) state <= jpeg_capture_pkg::cap_wait_frame;
                jpeg_capture_pkg::cap_wait_frame:
                    if (frame_valid_in) state <= jpeg_capture_pkg::cap_capture;
                jpeg_capture_pkg::cap_capture:
                    if (packer_done) state <= jpeg_capture_pkg::cap_done;
                default:                                    // idle or done
                    if (start_capture_in) state <= jpeg_capture_pkg::cap_arm;
            endcase
        end
    end

    always_comb begin
        packer_clear    = (state == jpeg_capture_pkg::cap_arm);
        // frame start cycle already belongs to the capture
        luma_en         = (state == jpeg_capture_pkg::cap_capture)
                        | ((state == jpeg_capture_pkg::cap_wait_frame) & frame_valid_in);
        image_valid_out = (state == jpeg_capture_pkg::cap_done);
    end

    luma_convert luma_convert_i (
        .jpeg_fast_clock_in   (jpeg_fast_clock_in),
        .jpeg_fast_reset_n_in (jpeg_fast_reset_n_in),
        .red                  (red_data_in),
        .green                (green_data_in),
        .blue                 (blue_data_in),
        .frame_valid_in       (frame_valid_in),
        .line_valid_in        (line_valid_in),
        .enable               (luma_en),
        .luma                 (luma),
        .luma_frame_valid     (luma_frame_valid),
        .luma_line_valid      (luma_line_valid)
    );

    frame_packer #(
        .SENSOR_X_SIZE (SENSOR_X_SIZE),
        .SENSOR_Y_SIZE (SENSOR_Y_SIZE),
        .BUF_WORDS     (BUF_WORDS)
    ) frame_packer_i (
        .jpeg_fast_clock_in   (jpeg_fast_clock_in),
        .jpeg_fast_reset_n_in (jpeg_fast_reset_n_in),
        .clear                (packer_clear),
        .luma                 (luma),
        .luma_frame_valid     (luma_frame_valid),
        .luma_line_valid      (luma_line_valid),
        .x_size_in            (x_size_in),
        .y_size_in            (y_size_in),
        .wr_bus               (wr_bus.master),
        .done                 (packer_done),
        .byte_count           (image_bytes_out)     // stored luma bytes
    );

    shared_image_buffer #(
        .BUF_WORDS (BUF_WORDS)
    ) shared_image_buffer_i (
        .jpeg_fast_clock_in   (jpeg_fast_clock_in),
        .jpeg_fast_reset_n_in (jpeg_fast_reset_n_in),
        .wr_bus               (wr_bus.buffer),
        .rd_bus               (rd_bus.buffer)
    );

    apb_buffer_reader #(
        .BUF_WORDS (BUF_WORDS)
    ) apb_buffer_reader_i (
        .jpeg_fast_clock_in   (jpeg_fast_clock_in),
        .jpeg_fast_reset_n_in (jpeg_fast_reset_n_in),
        .psel                 (psel),
        .penable              (penable),
        .pwrite               (pwrite),
        .paddr                (paddr),
        .prdata               (prdata),
        .pready               (pready),
        .pslverr              (pslverr),
        .rd_bus               (rd_bus.master)
    );

endmodule

/* dv/jpeg_encoder_tb.sv */
// frame capture testbench
`timescale 1ns/10ps

module jpeg_encoder_tb;

    localparam int          SX         = 15;           // 15 by 7 gives 105 pixels and a padded tail
    localparam int          SY         = 7;
    localparam int          BUF_WORDS  = 64;
    localparam int          XW         = $clog2(SX + 1);
    localparam int          YW         = $clog2(SY + 1);
    localparam int          BW         = $clog2(SX * SY + 1);
    localparam int          CROP_X     = 6;
    localparam int          CROP_Y     = 3;
    localparam int          FULL_WORDS = (SX * SY + 3) / 4;
    localparam int          CROP_WORDS = (CROP_X * CROP_Y + 3) / 4;
    localparam int          LINE_GAP   = 3;            // idle cycles between lines
    localparam int          READ_DELAY = 22;           // first read meets the second word write
    localparam int          CLK_PERIOD = 4;
    localparam logic [31:0] SEED       = 32'h6814169c;
    // three frames at twice their length plus every APB read
    localparam int FRAME_CYCLES   = 8 + SY * (SX + LINE_GAP);
    localparam int N_READS        = 2 * FULL_WORDS + 3;
    localparam int TIMEOUT_CYCLES = 2 * 3 * FRAME_CYCLES + 5 * N_READS + 20;

    logic                    jpeg_fast_clock_in;
    logic                    jpeg_fast_reset_n_in;
    logic                    start_capture_in;
    logic [9:0]              red_data_in;
    logic [9:0]              green_data_in;
    logic [9:0]              blue_data_in;
    logic                    frame_valid_in;
    logic                    line_valid_in;
    logic [XW-1:0]           x_size_in;
    logic [YW-1:0]           y_size_in;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [15:0]             paddr;
    jpeg_capture_pkg::word_t prdata;
    logic                    pready;
    logic                    pslverr;
    logic                    image_valid_out;
    logic [BW-1:0]           image_bytes_out;

    logic [9:0]              red_px   [SY][SX];        // stimulus of the current frame
    logic [9:0]              green_px [SY][SX];
    logic [9:0]              blue_px  [SY][SX];
    jpeg_capture_pkg::word_t exp_mem  [BUF_WORDS];     // model of the buffer contents
    jpeg_capture_pkg::word_t exp_word;                 // expectation of the running read
    logic                    exp_err;
    logic [15:0]             exp_addr;
    int                      reads_done = 0;
    int                      errors     = 0;

    jpeg_encoder #(
        .SENSOR_X_SIZE (SX),
        .SENSOR_Y_SIZE (SY),
        .BUF_WORDS     (BUF_WORDS)
    ) dut_i (.*);

    initial begin
        jpeg_fast_clock_in = 1'b0;
        forever #(CLK_PERIOD / 2) jpeg_fast_clock_in = ~jpeg_fast_clock_in;
    end

    task automatic stop_on_error();
        errors++;
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(string sig, int expected, int actual);
        assert (expected == actual) else begin
            $display("ERR %0t %s expected %0d got %0d", $time, sig, expected, actual);
            stop_on_error();
        end
    endtask

    // luma from the upper 8 bits of each colour
    function automatic jpeg_capture_pkg::pixel_t ref_luma(logic [9:0] r, logic [9:0] g,
                                                          logic [9:0] b);
        int sum;
        sum = jpeg_capture_pkg::LUMA_R * int'(r[9:2])
            + jpeg_capture_pkg::LUMA_G * int'(g[9:2])
            + jpeg_capture_pkg::LUMA_B * int'(b[9:2]);
        return jpeg_capture_pkg::pixel_t'(sum >> 8);
    endfunction

    // crop in raster order and pack four pixels per word with pixel 0 in the low byte
    function automatic void build_expected(int xs, int ys);
        int n;
        n = 0;
        for (int w = 0; w < (xs * ys + 3) / 4; w++)
            exp_mem[w] = '0;                           // tail bytes stay zero
        for (int y = 0; y < ys; y++) begin
            for (int x = 0; x < xs; x++) begin
                exp_mem[n / 4][8 * (n % 4) +: 8] = ref_luma(red_px[y][x], green_px[y][x],
                                                            blue_px[y][x]);
                n++;
            end
        end
    endfunction

    task automatic fill_frame();
        for (int y = 0; y < SY; y++) begin
            for (int x = 0; x < SX; x++) begin
                red_px[y][x]   = 10'($urandom);
                green_px[y][x] = 10'($urandom);
                blue_px[y][x]  = 10'($urandom);
            end
        end
    endtask

    // one full sensor frame with idle gaps between lines
    task automatic drive_frame();
        @(posedge jpeg_fast_clock_in);
        frame_valid_in <= 1'b1;
        repeat (2) @(posedge jpeg_fast_clock_in);    // front porch
        for (int y = 0; y < SY; y++) begin
            for (int x = 0; x < SX; x++) begin
                line_valid_in <= 1'b1;
                red_data_in   <= red_px[y][x];
                green_data_in <= green_px[y][x];
                blue_data_in  <= blue_px[y][x];
                @(posedge jpeg_fast_clock_in);
            end
            line_valid_in <= 1'b0;
            repeat (LINE_GAP) @(posedge jpeg_fast_clock_in);
        end
        frame_valid_in <= 1'b0;
        repeat (4) @(posedge jpeg_fast_clock_in);    // vertical blank
    endtask

    task automatic pulse_start();
        @(posedge jpeg_fast_clock_in);
        start_capture_in <= 1'b1;
        @(posedge jpeg_fast_clock_in);
        start_capture_in <= 1'b0;
    endtask

    task automatic wait_image_valid();
        @(posedge jpeg_fast_clock_in);
        while (!image_valid_out) @(posedge jpeg_fast_clock_in);
    endtask

    // setup cycle then access until pready
    task automatic apb_access(logic [15:0] addr, logic write, jpeg_capture_pkg::word_t data,
                              logic err);
        @(posedge jpeg_fast_clock_in);
        exp_word = data;
        exp_err  = err;
        exp_addr = addr;
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        @(posedge jpeg_fast_clock_in);
        penable <= 1'b1;
        @(posedge jpeg_fast_clock_in);
        while (!pready) @(posedge jpeg_fast_clock_in);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // compare every completed APB transfer
    always @(posedge jpeg_fast_clock_in) begin
        if (psel && penable && pready) begin
            reads_done++;
            assert (pslverr == exp_err) else begin
                $display("ERR %0t pslverr expected %b got %b", $time, exp_err, pslverr);
                stop_on_error();
            end
            if (!exp_err) begin
                assert (prdata == exp_word) else begin
                    $display("ERR %0t prdata at 0x%h expected %h got %h", $time, exp_addr,
                             exp_word, prdata);
                    stop_on_error();
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, a capture or an APB read never ended",
                 TIMEOUT_CYCLES);
        stop_on_error();
    end

    initial begin
        int seed_ret;
        seed_ret             = $urandom(SEED);
        jpeg_fast_reset_n_in = 1'b0;
        start_capture_in     = 1'b0;
        red_data_in          = '0;
        green_data_in        = '0;
        blue_data_in         = '0;
        frame_valid_in       = 1'b0;
        line_valid_in        = 1'b0;
        x_size_in            = XW'(SX);
        y_size_in            = YW'(SY);
        psel                 = 1'b0;
        penable              = 1'b0;
        pwrite               = 1'b0;
        paddr                = '0;
        repeat (2) @(posedge jpeg_fast_clock_in);
        jpeg_fast_reset_n_in <= 1'b1;
        @(posedge jpeg_fast_clock_in);
        check_value("image_valid_out", 0, image_valid_out);
        check_value("pready", 0, pready);
        check_value("pslverr", 0, pslverr);
        check_value("image_bytes_out", 0, image_bytes_out);
        check_value("state", int'(jpeg_capture_pkg::cap_idle), int'(dut_i.state));

        // start lands inside a running frame that must be skipped
        fill_frame();
        fork
            drive_frame();
            begin
                repeat (20) @(posedge jpeg_fast_clock_in);
                pulse_start();
            end
        join
        fill_frame();                                  // the frame that gets stored
        build_expected(SX, SY);
        drive_frame();
        wait_image_valid();
        $display("full capture finished in state %s", dut_i.state.name());
        check_value("image_bytes_out", SX * SY, image_bytes_out);
        for (int w = 0; w < FULL_WORDS; w++)
            apb_access(16'(4 * w), 1'b0, exp_mem[w], 1'b0);

        // smaller crop while the host reads the old words beyond it
        x_size_in <= XW'(CROP_X);
        y_size_in <= YW'(CROP_Y);
        pulse_start();
        fill_frame();
        build_expected(CROP_X, CROP_Y);                // words past the crop keep frame one
        fork
            drive_frame();
            begin
                // read requests fall on word write requests, the reader wins twice
                // and then the writer once
                repeat (READ_DELAY) @(posedge jpeg_fast_clock_in);
                for (int w = CROP_WORDS; w < FULL_WORDS; w++)
                    apb_access(16'(4 * w), 1'b0, exp_mem[w], 1'b0);
            end
        join
        wait_image_valid();
        check_value("image_bytes_out", CROP_X * CROP_Y, image_bytes_out);
        for (int w = 0; w < CROP_WORDS; w++)
            apb_access(16'(4 * w), 1'b0, exp_mem[w], 1'b0);

        // writes and out of range reads
        apb_access(16'h0000, 1'b1, '0, 1'b1);
        apb_access(16'(4 * BUF_WORDS), 1'b0, '0, 1'b1);
        apb_access(16'hfffc, 1'b0, '0, 1'b1);
        @(posedge jpeg_fast_clock_in);
        check_value("apb transfers checked", N_READS, reads_done);

        if (errors == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            stop_on_error();
        end
    end

endmodule

/* files.f */
hdl/jpeg_capture_pkg.sv
hdl/buf_req_if.sv
hdl/luma_convert.sv
hdl/frame_packer.sv
hdl/shared_image_buffer.sv
hdl/apb_buffer_reader.sv
hdl/jpeg_encoder.sv
dv/jpeg_encoder_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing -Wno-fatal --timescale 1ns/10ps -f files.f \
    --top-module jpeg_encoder_tb -o jpeg_encoder_sim > build.log 2>&1 &&
./obj_dir/jpeg_encoder_sim > sim.log 2>&1
grep -q "TB PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
